//--- include/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// Datapath width in bits
`define XLEN 32

// Integer register count, x0 included
`define NUM_REGS 32

// Multiplier operand bits retired per cycle
// Multiplier latency is XLEN / MUL_STEP cycles
`define MUL_STEP 8

// First PC the pipeline expects after reset
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/backend_pkg.sv
`include "backend_macros.svh"

package backend_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       reg_idx_t;

  // Pre-decoded operations
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL,
    OP_BEQ,
    OP_JAL
  } op_e;

  // Where a stage takes its result from
  typedef enum logic {
    FU_ALU,
    FU_MUL
  } func_unit_e;

  typedef enum logic [1:0] {
    ST_NORMAL,
    ST_MISPREDICT,
    ST_FLUSH
  } issue_state_e;

  // Instruction as delivered by the frontend
  // Operand B of ALU ops is rs2 plus imm, so one of them is usually zero
  typedef struct packed {
    word_t    pc;
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     redirected;
  } fetch_instr_t;

  // Retire report, also the register file write port
  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    word_t    data;
  } commit_t;

  typedef struct packed {
    logic     pending;
    reg_idx_t rd;
    logic     data_valid;
    word_t    data;
  } stage_fwd_t;

endpackage

//--- hdl/int_reg_file.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module int_reg_file import backend_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  reg_idx_t raddr_a_i,
  input  reg_idx_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  input  commit_t  wr_i
);

  word_t regs_q [`NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.valid && wr_i.rd != '0) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // x0 always reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hdl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import backend_pkg::*; (
  input  fetch_instr_t de_instr_i,
  input  word_t        rf_rs1_i,
  input  word_t        rf_rs2_i,
  input  stage_fwd_t   ex1_fwd_i,
  input  stage_fwd_t   ex2_fwd_i,
  output word_t        rs1_o,
  output word_t        rs2_o,
  output logic         data_hazard_o
);

  // A stage is a source for idx if it will write that register
  function automatic logic fwd_hit(stage_fwd_t fwd, reg_idx_t idx);
    return fwd.pending && fwd.rd == idx && idx != '0;
  endfunction

  // EX2 is checked first so the younger EX1 value wins
  always_comb begin
    rs1_o = rf_rs1_i;
    rs2_o = rf_rs2_i;
    data_hazard_o = 1'b0;

    if (fwd_hit(ex2_fwd_i, de_instr_i.rs1)) begin
      if (ex2_fwd_i.data_valid) begin
        rs1_o = ex2_fwd_i.data;
      end else begin
        data_hazard_o = 1'b1;
      end
    end
    if (fwd_hit(ex1_fwd_i, de_instr_i.rs1)) begin
      if (ex1_fwd_i.data_valid) begin
        rs1_o = ex1_fwd_i.data;
      end else begin
        data_hazard_o = 1'b1;
      end
    end

    if (fwd_hit(ex2_fwd_i, de_instr_i.rs2)) begin
      if (ex2_fwd_i.data_valid) begin
        rs2_o = ex2_fwd_i.data;
      end else begin
        data_hazard_o = 1'b1;
      end
    end
    if (fwd_hit(ex1_fwd_i, de_instr_i.rs2)) begin
      if (ex1_fwd_i.data_valid) begin
        rs2_o = ex1_fwd_i.data;
      end else begin
        data_hazard_o = 1'b1;
      end
    end
  end

endmodule

//--- hdl/iter_multiplier.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module iter_multiplier import backend_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  word_t operand_a_i,
  input  word_t operand_b_i,
  output logic  resp_valid_o,
  output word_t resp_data_o
);

  localparam int unsigned num_steps = `XLEN / `MUL_STEP;
  localparam int unsigned cnt_w = $clog2(num_steps);

  logic             busy_q;
  logic [cnt_w-1:0] cnt_q;
  logic             resp_valid_q;
  logic             accept;

  word_t acc_q, acc_d;
  word_t mcand_q;
  word_t mplier_q;

  assign req_ready_o = !busy_q;
  assign accept = req_valid_i && req_ready_o;

  // One step adds up to MUL_STEP shifted copies of the multiplicand
  always_comb begin
    acc_d = acc_q;
    for (int i = 0; i < `MUL_STEP; i++) begin
      if (mplier_q[i]) begin
        acc_d = acc_d + (mcand_q << i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == cnt_w'(num_steps - 1)) begin
          busy_q <= 1'b0;
          resp_valid_q <= 1'b1;
        end
      end
    end
  end

  // Multiplicand moves up and multiplier moves down by one step each cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_q <= '0;
      mcand_q <= operand_a_i;
      mplier_q <= operand_b_i;
    end else if (busy_q) begin
      acc_q <= acc_d;
      mcand_q <= mcand_q << `MUL_STEP;
      mplier_q <= mplier_q >> `MUL_STEP;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o = acc_q;

  // Issue logic must hold MULs back while a product is in progress
  no_req_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) busy_q |-> !req_valid_i
  );

endmodule

//--- hdl/exec_pipe.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module exec_pipe import backend_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         issue_i,
  input  fetch_instr_t de_instr_i,
  input  word_t        rs1_i,
  input  word_t        rs2_i,
  input  logic         mul_valid_i,
  input  word_t        mul_data_i,
  output logic         mul_req_o,
  output stage_fwd_t   ex1_fwd_o,
  output stage_fwd_t   ex2_fwd_o,
  output logic         ex1_ready_o,
  output word_t        expected_pc_o,
  output commit_t      commit_o
);

  typedef struct packed {
    logic       pending;
    func_unit_e select;
    reg_idx_t   rd;
    word_t      pc;
    word_t      data;
  } stage_t;

  stage_t ex1_q, ex1_d;
  stage_t ex2_q, ex2_d;
  word_t  expected_pc_q, expected_pc_d;

  word_t operand_b;
  word_t link_pc;
  word_t target_pc;
  word_t alu_result;
  logic  branch_taken;

  logic  ex1_data_valid;
  word_t ex1_data;
  logic  ex2_data_valid;
  word_t ex2_data;
  logic  ex2_ready;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and branch compare
  ////////////////////////////////////////////////////////////////////////////

  assign operand_b    = rs2_i + de_instr_i.imm;
  assign link_pc      = de_instr_i.pc + word_t'(4);
  assign target_pc    = de_instr_i.pc + de_instr_i.imm;
  assign branch_taken = rs1_i == rs2_i;

  // Jumps and branches carry the link value
  always_comb begin
    case (de_instr_i.op)
      OP_ADD:  alu_result = rs1_i + operand_b;
      OP_SUB:  alu_result = rs1_i - operand_b;
      OP_AND:  alu_result = rs1_i & operand_b;
      OP_OR:   alu_result = rs1_i | operand_b;
      OP_XOR:  alu_result = rs1_i ^ operand_b;
      default: alu_result = link_pc;
    endcase
  end

  assign mul_req_o = issue_i && de_instr_i.op == OP_MUL;

  ////////////////////////////////////////////////////////////////////////////
  // EX1 stage
  ////////////////////////////////////////////////////////////////////////////

  assign ex2_ready   = !ex2_q.pending || ex2_data_valid;
  assign ex1_ready_o = ex2_ready || !ex1_q.pending;

  always_comb begin
    case (ex1_q.select)
      // A response seen while EX2 waits on a MUL belongs to EX2
      FU_MUL: begin
        ex1_data_valid = mul_valid_i && ex2_q.select != FU_MUL;
        ex1_data = mul_data_i;
      end
      default: begin
        ex1_data_valid = 1'b1;
        ex1_data = ex1_q.data;
      end
    endcase
  end

  always_comb begin
    ex1_d = ex1_q;
    expected_pc_d = expected_pc_q;

    // Keep an early result even if EX1 cannot move on yet
    if (ex1_data_valid) begin
      ex1_d.select = FU_ALU;
      ex1_d.data = ex1_data;
    end

    if (ex2_ready) begin
      ex1_d.pending = 1'b0;
      ex1_d.select = FU_ALU;
      ex1_d.rd = '0;
    end

    if (issue_i) begin
      ex1_d.pending = 1'b1;
      ex1_d.select = (de_instr_i.op == OP_MUL) ? FU_MUL : FU_ALU;
      // Branches write no register
      ex1_d.rd = (de_instr_i.op == OP_BEQ) ? '0 : de_instr_i.rd;
      ex1_d.pc = de_instr_i.pc;
      ex1_d.data = alu_result;

      expected_pc_d = link_pc;
      if (de_instr_i.op == OP_JAL || (de_instr_i.op == OP_BEQ && branch_taken)) begin
        expected_pc_d = target_pc;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX2 stage
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ex2_q.select)
      FU_MUL: begin
        ex2_data_valid = mul_valid_i;
        ex2_data = mul_data_i;
      end
      default: begin
        ex2_data_valid = 1'b1;
        ex2_data = ex2_q.data;
      end
    endcase
  end

  always_comb begin
    ex2_d = ex2_q;

    if (ex2_data_valid) begin
      ex2_d.pending = 1'b0;
      ex2_d.select = FU_ALU;
      ex2_d.rd = '0;
    end

    if (ex1_q.pending && ex2_ready) begin
      ex2_d = ex1_q;
      if (ex1_data_valid) begin
        ex2_d.select = FU_ALU;
        ex2_d.data = ex1_data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_q <= '0;
      ex2_q <= '0;
      expected_pc_q <= `RESET_PC;
    end else begin
      ex1_q <= ex1_d;
      ex2_q <= ex2_d;
      expected_pc_q <= expected_pc_d;
    end
  end

  assign expected_pc_o = expected_pc_q;

  assign ex1_fwd_o = '{
    pending:    ex1_q.pending,
    rd:         ex1_q.rd,
    data_valid: ex1_data_valid,
    data:       ex1_data
  };

  assign ex2_fwd_o = '{
    pending:    ex2_q.pending,
    rd:         ex2_q.rd,
    data_valid: ex2_data_valid,
    data:       ex2_data
  };

  assign commit_o = '{
    valid: ex2_q.pending && ex2_data_valid,
    pc:    ex2_q.pc,
    rd:    ex2_q.rd,
    data:  ex2_data
  };

  // A multiplier response always finds its MUL waiting in EX2 and retires it
  mul_resp_commits: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mul_valid_i |-> ex2_q.pending && ex2_q.select == FU_MUL && commit_o.valid
  );

endmodule

//--- hdl/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl import backend_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         fetch_valid_i,
  output logic         fetch_ready_o,
  input  fetch_instr_t fetch_instr_i,
  input  logic         data_hazard_i,
  input  logic         ex1_ready_i,
  input  logic         mul_ready_i,
  input  word_t        expected_pc_i,
  output fetch_instr_t de_instr_o,
  output reg_idx_t     rs1_sel_o,
  output reg_idx_t     rs2_sel_o,
  output logic         issue_o,
  output logic         redirect_valid_o,
  output word_t        redirect_pc_o
);

  logic         de_valid_q;
  fetch_instr_t de_instr_q;
  logic         de_ready;

  issue_state_e state_q;
  issue_state_e state_d;

  logic pc_mismatch;
  logic struct_hazard;
  logic control_hazard;

  ////////////////////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////////////////////

  assign fetch_ready_o = !de_valid_q || de_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      de_valid_q <= 1'b0;
    end else if (fetch_valid_i && fetch_ready_o) begin
      de_valid_q <= 1'b1;
    end else if (de_valid_q && de_ready) begin
      de_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i && fetch_ready_o) begin
      de_instr_q <= fetch_instr_i;
    end
  end

  assign de_instr_o = de_instr_q;
  // Register file is read straight from the held instruction
  assign rs1_sel_o  = de_instr_q.rs1;
  assign rs2_sel_o  = de_instr_q.rs2;

  ////////////////////////////////////////////////////////////////////////////
  // Hazards
  ////////////////////////////////////////////////////////////////////////////

  // Only one MUL may be in the multiplier at a time
  assign struct_hazard = !ex1_ready_i || (de_instr_q.op == OP_MUL && !mul_ready_i);
  assign pc_mismatch   = expected_pc_i != de_instr_q.pc;

  // Wrong-path instructions are dropped until the redirected stream shows up
  always_comb begin
    case (state_q)
      ST_NORMAL: control_hazard = pc_mismatch;
      default:   control_hazard = !de_instr_q.redirected;
    endcase
  end

  assign issue_o  = de_valid_q && !data_hazard_i && !struct_hazard && !control_hazard;
  assign de_ready = (!data_hazard_i && !struct_hazard) || control_hazard;

  ////////////////////////////////////////////////////////////////////////////
  // Issue FSM and redirect
  ////////////////////////////////////////////////////////////////////////////

  assign redirect_valid_o = state_q == ST_NORMAL && de_valid_q && pc_mismatch;
  assign redirect_pc_o    = expected_pc_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_NORMAL: begin
        if (redirect_valid_o) begin
          state_d = ST_MISPREDICT;
        end
      end
      // Anything issued here carries the redirected flag
      ST_MISPREDICT, ST_FLUSH: begin
        if (issue_o) begin
          state_d = ST_NORMAL;
        end
      end
      default: state_d = ST_FLUSH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_FLUSH;
    end else begin
      state_q <= state_d;
    end
  end

  // An issued instruction was loaded last cycle or held over from it
  issue_needs_instr: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_o |-> $past(fetch_valid_i && fetch_ready_o) || $past(de_valid_q && !de_ready)
  );

endmodule

//--- hdl/int_backend.sv
`timescale 1ns/1ps

module int_backend import backend_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         fetch_valid_i,
  output logic         fetch_ready_o,
  input  fetch_instr_t fetch_instr_i,
  output logic         redirect_valid_o,
  output word_t        redirect_pc_o,
  output commit_t      commit_o
);

  fetch_instr_t de_instr;
  reg_idx_t     rs1_sel;
  reg_idx_t     rs2_sel;
  word_t        rf_rs1;
  word_t        rf_rs2;
  word_t        ex_rs1;
  word_t        ex_rs2;
  stage_fwd_t   ex1_fwd;
  stage_fwd_t   ex2_fwd;
  logic         data_hazard;
  logic         ex1_ready;
  logic         issue;
  word_t        expected_pc;
  logic         mul_req;
  logic         mul_ready;
  logic         mul_valid;
  word_t        mul_data;

  issue_ctrl issue_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_ready_o    (fetch_ready_o),
    .fetch_instr_i    (fetch_instr_i),
    .data_hazard_i    (data_hazard),
    .ex1_ready_i      (ex1_ready),
    .mul_ready_i      (mul_ready),
    .expected_pc_i    (expected_pc),
    .de_instr_o       (de_instr),
    .rs1_sel_o        (rs1_sel),
    .rs2_sel_o        (rs2_sel),
    .issue_o          (issue),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  int_reg_file int_reg_file_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_sel),
    .raddr_b_i (rs2_sel),
    .rdata_a_o (rf_rs1),
    .rdata_b_o (rf_rs2),
    .wr_i      (commit_o)
  );

  operand_bypass operand_bypass_inst (
    .de_instr_i    (de_instr),
    .rf_rs1_i      (rf_rs1),
    .rf_rs2_i      (rf_rs2),
    .ex1_fwd_i     (ex1_fwd),
    .ex2_fwd_i     (ex2_fwd),
    .rs1_o         (ex_rs1),
    .rs2_o         (ex_rs2),
    .data_hazard_o (data_hazard)
  );

  exec_pipe exec_pipe_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .de_instr_i    (de_instr),
    .rs1_i         (ex_rs1),
    .rs2_i         (ex_rs2),
    .mul_valid_i   (mul_valid),
    .mul_data_i    (mul_data),
    .mul_req_o     (mul_req),
    .ex1_fwd_o     (ex1_fwd),
    .ex2_fwd_o     (ex2_fwd),
    .ex1_ready_o   (ex1_ready),
    .expected_pc_o (expected_pc),
    .commit_o      (commit_o)
  );

  iter_multiplier iter_multiplier_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (mul_req),
    .req_ready_o  (mul_ready),
    .operand_a_i  (ex_rs1),
    .operand_b_i  (ex_rs2),
    .resp_valid_o (mul_valid),
    .resp_data_o  (mul_data)
  );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_no <= 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- dv/backend_checker.sv
`timescale 1ns/1ps

module backend_checker import backend_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  commit_t commit_i,
  input  logic    redirect_valid_i,
  input  word_t   redirect_pc_i,
  input  logic    report_i,
  output logic    done_o,
  output logic    reported_o,
  output int      errors_o
);

  word_t    c_pc[$];
  reg_idx_t c_rd[$];
  word_t    c_data[$];
  word_t    r_pc[$];
  string    names[$];
  int       c_end[$];
  int       r_end[$];

  int ci = 0;
  int ri = 0;
  int cur = 0;
  int test_errs = 0;
  int clean = 0;
  int errors = 0;

  task automatic load_expected();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("dv/backend_input.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0) begin
        if (line[0] == "T") begin
          code = $sscanf(line, "T %s", name);
          names.push_back(name);
          c_end.push_back(c_pc.size());
          r_end.push_back(r_pc.size());
        end else if (line[0] == "C") begin
          code = $sscanf(line, "C %h %h %h", a, b, c);
          c_pc.push_back(a);
          c_rd.push_back(b[4:0]);
          c_data.push_back(c);
          c_end[c_end.size()-1] = c_pc.size();
        end else if (line[0] == "R") begin
          code = $sscanf(line, "R %h", a);
          r_pc.push_back(a);
          r_end[r_end.size()-1] = r_pc.size();
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    reported_o <= 1'b0;
    load_expected();
  end

  task automatic compare(string sig, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Fail: %s expected %h, got %h", sig, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (commit_i.valid) begin
        if (ci >= c_pc.size()) begin
          $display("Commit at pc %h arrived after the expected list ended", commit_i.pc);
          errors++;
        end else begin
          compare("commit_o.pc", c_pc[ci], commit_i.pc);
          compare("commit_o.rd", 32'(c_rd[ci]), 32'(commit_i.rd));
          compare("commit_o.data", c_data[ci], commit_i.data);
          ci++;
        end
      end
      if (redirect_valid_i) begin
        if (ri >= r_pc.size()) begin
          $display("Unexpected redirect to %h", redirect_pc_i);
          errors++;
        end else begin
          compare("redirect_pc_o", r_pc[ri], redirect_pc_i);
          ri++;
        end
      end
      // A test is over once all its commits and redirects are seen
      while (cur < names.size() && ci >= c_end[cur] && ri >= r_end[cur]) begin
        if (test_errs == 0) begin
          $display("[%0s] ok", names[cur]);
          clean++;
        end else begin
          $display("[%0s] %0d mismatches", names[cur], test_errs);
        end
        test_errs = 0;
        cur++;
      end
      if (report_i && !reported_o) begin
        $display("Summary: %0d of %0d tests clean, %0d errors, %0d commits, %0d redirects",
                 clean, names.size(), errors, ci, ri);
        reported_o <= 1'b1;
      end
    end
  end

  assign done_o   = cur == names.size();
  assign errors_o = errors;

endmodule

//--- dv/tb_int_backend.sv
`timescale 1ns/1ps

module tb_int_backend import backend_pkg::*; ();

  logic         clk_i;
  logic         rst_ni;
  logic         fetch_valid_i;
  logic         fetch_ready_o;
  fetch_instr_t fetch_instr_i;
  logic         redirect_valid_o;
  word_t        redirect_pc_o;
  commit_t      commit_o;

  logic report;
  logic reported;
  logic all_done;
  int   errors;

  fetch_instr_t instr_q[$];
  int           instr_idx;
  int           cycle_cnt;
  int           cycle_limit;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  int_backend int_backend_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_ready_o    (fetch_ready_o),
    .fetch_instr_i    (fetch_instr_i),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .commit_o         (commit_o)
  );

  backend_checker backend_checker_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .commit_i         (commit_o),
    .redirect_valid_i (redirect_valid_o),
    .redirect_pc_i    (redirect_pc_o),
    .report_i         (report),
    .done_o           (all_done),
    .reported_o       (reported),
    .errors_o         (errors)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Instruction records from the data file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_instrs();
    int           fd;
    int           code;
    string        line;
    logic [31:0]  f[7];
    fetch_instr_t ins;
    fd = $fopen("dv/backend_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/backend_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0 && line[0] == "I") begin
        code = $sscanf(line, "I %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        ins.pc         = f[0];
        ins.op         = op_e'(f[1][2:0]);
        ins.rd         = f[2][4:0];
        ins.rs1        = f[3][4:0];
        ins.rs2        = f[4][4:0];
        ins.imm        = f[5];
        ins.redirected = f[6][0];
        instr_q.push_back(ins);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    fetch_valid_i <= 1'b0;
    fetch_instr_i <= '0;
    report        <= 1'b0;
    cycle_cnt     <= 0;
    instr_idx     = 0;
    void'($urandom(32'ha3ef));
    load_instrs();
    if (instr_q.size() == 0) begin
      $display("No instruction records were loaded from the data file");
      $display("Test failed");
      $finish;
    end else begin
      // 50 cycles per instruction on top of the reset time
      cycle_limit = 50 * instr_q.size() + 16;
    end
  end

  // Fetch stream with random gaps; an offered instruction stays until taken
  initial begin
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      if (fetch_valid_i && fetch_ready_o) begin
        instr_idx = instr_idx + 1;
      end
      if (!(fetch_valid_i && !fetch_ready_o)) begin
        if (instr_idx < instr_q.size() && $urandom_range(3, 0) != 0) begin
          fetch_valid_i <= 1'b1;
          fetch_instr_i <= instr_q[instr_idx];
        end else begin
          fetch_valid_i <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles with expected records still open", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // End of run
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wait (rst_ni === 1'b1);
    wait (all_done === 1'b1);
    // Extra cycles so a stray late commit is still seen
    repeat (20) @(posedge clk_i);
    report <= 1'b1;
    wait (reported === 1'b1);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/backend_input.txt
# T name | I pc op rd rs1 rs2 imm redirected | C pc rd data | R pc   (hex fields)
# op: 0 add 1 sub 2 and 3 or 4 xor 5 mul 6 beq 7 jal
T alu
I 0 0 1 0 0 5 1
I 4 0 2 0 0 7 0
I 8 4 3 0 0 ffffffff 0
I c 0 4 0 0 80000000 0
C 0 1 5
C 4 2 7
C 8 3 ffffffff
C c 4 80000000
T bypass
I 10 0 5 3 0 2 0
I 14 1 6 5 1 0 0
I 18 3 7 6 5 0 0
I 1c 2 8 7 6 0 0
C 10 5 1
C 14 6 fffffffc
C 18 7 fffffffd
C 1c 8 fffffffc
T mul
I 20 5 9 7 1 0 0
I 24 0 a 9 9 0 0
I 28 5 b 1 2 0 0
C 20 9 fffffff1
C 24 a ffffffe2
C 28 b 23
T branch
I 2c 6 0 0 0 10 0
I 30 0 c 0 0 99 0
I 34 0 d 0 0 99 0
I 3c 7 e 0 0 20 1
I 40 0 f 0 0 1 0
I 5c 0 f e 0 4 1
C 2c 0 30
R 3c
C 3c e 40
R 5c
C 5c f 44
T x0
I 60 0 0 0 0 123 0
I 64 0 10 0 0 1 0
I 68 6 0 1 2 8 0
C 60 0 123
C 64 10 1
C 68 0 6c

//--- vlog.f
+incdir+include
hdl/backend_pkg.sv
hdl/int_reg_file.sv
hdl/operand_bypass.sv
hdl/iter_multiplier.sv
hdl/exec_pipe.sv
hdl/issue_ctrl.sv
hdl/int_backend.sv
dv/tb_clock_gen.sv
dv/backend_checker.sv
dv/tb_int_backend.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_int_backend \
  -f vlog.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  exit 1
fi
